// ==== verif/controlGolden.txt ====
# name opcode funct overflow cycles wb(regDst,memToReg or ff) events addr branch
# events: memWrite epcWrite pcWriteCond hiLoWrite multStart jump
add       00 20 0 6  10 000000 0 0
sub       00 22 0 6  10 000000 0 0
and       00 24 0 6  10 000000 0 0
slt       00 2a 0 6  10 000000 0 0
andOvf    00 24 1 6  10 000000 0 0
sltOvf    00 2a 1 6  10 000000 0 0
addi      08 00 0 6  00 000000 0 0
addiu     09 00 0 6  00 000000 0 0
addiuOvf  09 00 1 6  00 000000 0 0
slti      0a 00 0 6  00 000000 0 0
lw        23 00 0 9  01 000000 0 0
sw        2b 00 0 6  ff 100000 1 0
beq       04 00 0 5  ff 001000 0 2
bne       05 00 0 5  ff 001000 0 1
j         02 00 0 5  ff 000001 0 0
jal       03 00 0 6  26 000001 0 0
mult      00 18 0 39 ff 000110 0 0
addOvf    00 20 1 9  ff 010000 3 0
subOvf    00 22 1 9  ff 010000 3 0
addiOvf   08 00 1 9  ff 010000 3 0
badOpcode 3f 00 0 8  ff 010000 2 0
badFunct  00 3f 0 8  ff 010000 2 0
multAgain 00 18 1 39 ff 000110 0 0
addAfter  00 20 0 6  10 000000 0 0

// ==== mipsControlUnit.f ====
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/controlSequencer.sv
hw/controlWordGen.sv
hw/mipsControlUnit.sv
verif/mipsControlUnitTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = mipsControlUnitTb
FILELIST  = mipsControlUnit.f

.PHONY: sim clean

# status of the run comes from grep finding the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== verif/mipsControlUnitTb.sv ====
module mipsControlUnitTb
    import isaPkg::*, ctrlPkg::*;
();

    localparam int multWaitCycles = 33;
    localparam int clkPeriod      = 100;
    localparam int resetCycles    = 8;
    localparam int stepDelay      = 5;
    localparam int maxRows        = 64;
    localparam int cycleCap       = 6 + multWaitCycles + 4;

    logic     clk;
    logic     rstN;
    opcodeT   opcode;
    functT    funct;
    logic     overflow;
    ctrlWordT ctrl;

    // one entry per golden row
    logic [8*12-1:0] rowName   [maxRows];
    opcodeT          rowOpcode [maxRows];
    functT           rowFunct  [maxRows];
    logic            rowOvf    [maxRows];
    int              rowCycles [maxRows];
    logic [7:0]      rowWb     [maxRows];
    logic [5:0]      rowEvents [maxRows];
    logic [3:0]      rowAddr   [maxRows];
    logic [3:0]      rowBranch [maxRows];
    int              rowCount;
    logic            rowsLoaded;
    int              mismatchCount;
    int              otherErrors;

    mipsControlUnit #(
        .multWaitCycles (multWaitCycles)
    ) i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // pc <= pc + 4 with the read at pc
    function automatic logic isFetchMarker(ctrlWordT c);
        return c.pcWrite && (c.pcSrc == pcSeq) && (c.iOrD == addrPc)
            && (c.aluSrcB == srcBFour) && (c.aluOp == aluAdd);
    endfunction

    function automatic logic [7:0] wbCode(ctrlWordT c);
        return {2'b00, c.regDst, c.memToReg};
    endfunction

    task automatic advanceCycle();
        @(posedge clk);
        #stepDelay;  // ctrl settled, inputs may change
    endtask

    task automatic reportMismatch(logic [8*12-1:0] name, string what, int expVal, int actVal);
        $display("mismatch %0s %0s: expected %0h, actual %0h", name, what, expVal, actVal);
        mismatchCount++;
    endtask

    task automatic loadGolden();
        int              fd;
        int              got;
        string           line;
        logic [8*12-1:0] nameTmp;
        int              opTmp, fnTmp, ovfTmp, cycTmp, wbTmp, evTmp, addrTmp, brTmp;
        fd = $fopen("verif/controlGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file verif/controlGolden.txt");
            otherErrors++;
            return;
        end
        while (!$feof(fd) && rowCount < maxRows) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%s %h %h %d %d %h %b %h %h", nameTmp, opTmp, fnTmp,
                              ovfTmp, cycTmp, wbTmp, evTmp, addrTmp, brTmp);
                if (got == 9) begin
                    rowName[rowCount]   = nameTmp;
                    rowOpcode[rowCount] = opTmp[5:0];
                    rowFunct[rowCount]  = fnTmp[5:0];
                    rowOvf[rowCount]    = ovfTmp[0];
                    rowCycles[rowCount] = cycTmp;
                    rowWb[rowCount]     = wbTmp[7:0];
                    rowEvents[rowCount] = evTmp[5:0];
                    rowAddr[rowCount]   = addrTmp[3:0];
                    rowBranch[rowCount] = brTmp[3:0];
                    rowCount++;
                end else begin
                    $display("golden file has a row that could not be read: %0s", line);
                    otherErrors++;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin : mainFlow
        int         r;
        int         cycles;
        int         irAt;
        int         wbCount;
        int         repeats;
        int         mdrLoads;
        logic       done;
        logic       lost;
        logic       decodeLoad;
        logic       excJumpSeen;
        logic       expMdr;
        logic [5:0] eventNow;
        logic [5:0] seenEvents;
        logic [7:0] seenWb;
        logic [3:0] seenAddr;
        logic [3:0] seenBranch;
        clk           = 1'b0;
        rstN          = 1'b0;
        opcode        = opRType;
        funct         = fnAdd;
        overflow      = 1'b0;
        rowCount      = 0;
        rowsLoaded    = 1'b0;
        mismatchCount = 0;
        otherErrors   = 0;
        lost          = 1'b0;
        loadGolden();
        rowsLoaded = 1'b1;
        if (rowCount == 0) begin
            $display("no instructions were loaded from the golden file");
            otherErrors++;
            lost = 1'b1;
        end else begin
            repeat (resetCycles) begin
                advanceCycle();
                if (ctrl !== '0) reportMismatch("reset", "ctrl", 0, int'(ctrl));
            end
            rstN = 1'b1;
            advanceCycle();
            if (!ctrl.regWrite || wbCode(ctrl) != {2'b00, dstSp, wbSpInitConst}) begin
                reportMismatch("spInit", "writeback", {2'b00, dstSp, wbSpInitConst},
                               ctrl.regWrite ? wbCode(ctrl) : 8'hff);
            end
            advanceCycle();
            if (!isFetchMarker(ctrl)) begin
                $display("no fetch marker in the cycle after the stack pointer init");
                otherErrors++;
                lost = 1'b1;
            end
        end
        for (r = 0; r < rowCount && !lost; r++) begin
            cycles      = 1;
            irAt        = 0;
            wbCount     = 0;
            repeats     = 0;
            mdrLoads    = 0;
            decodeLoad  = 1'b0;
            excJumpSeen = 1'b0;
            seenEvents  = '0;
            seenWb      = 8'hff;  // none
            seenAddr    = '0;
            seenBranch  = '0;
            done        = 1'b0;
            while (!done) begin
                advanceCycle();
                if (isFetchMarker(ctrl)) begin
                    done = 1'b1;
                end else begin
                    cycles++;
                    eventNow = {ctrl.memWrite, ctrl.epcWrite, ctrl.pcWriteCond, ctrl.hiLoWrite,
                                ctrl.multStart, ctrl.pcWrite && (ctrl.pcSrc == pcJump)};
                    if ((eventNow & seenEvents) != '0) repeats++;
                    seenEvents = seenEvents | eventNow;
                    if (ctrl.regWrite) begin
                        wbCount++;
                        seenWb = wbCode(ctrl);
                    end
                    if (ctrl.epcWrite || ctrl.memWrite) seenAddr = {1'b0, ctrl.iOrD};
                    if (ctrl.pcWriteCond) seenBranch = {2'b00, ctrl.branchCond};
                    if (cycles == 4) decodeLoad = ctrl.regALoad && ctrl.regBLoad;
                    if (ctrl.pcWrite && (ctrl.pcSrc == pcExcVector)) excJumpSeen = 1'b1;
                    if (ctrl.mdrLoad) mdrLoads++;
                    if (ctrl.irWrite) begin  // this row's instruction enters IR
                        irAt     = cycles;
                        opcode   = rowOpcode[r];
                        funct    = rowFunct[r];
                        overflow = rowOvf[r];
                    end
                    if (cycles > cycleCap) begin
                        $display("no fetch marker within %0d cycles of %0s", cycleCap, rowName[r]);
                        otherErrors++;
                        lost = 1'b1;
                        done = 1'b1;
                    end
                end
            end
            if (!lost) begin
                if (cycles != rowCycles[r]) begin
                    $display("mismatch %0s cycles: expected %0d, actual %0d",
                             rowName[r], rowCycles[r], cycles);
                    mismatchCount++;
                end
                if (irAt != 3) reportMismatch(rowName[r], "irWrite cycle", 3, irAt);
                if (seenWb != rowWb[r]) reportMismatch(rowName[r], "writeback", rowWb[r], seenWb);
                if (seenEvents != rowEvents[r]) begin
                    reportMismatch(rowName[r], "events", rowEvents[r], seenEvents);
                end
                if (seenAddr != rowAddr[r]) reportMismatch(rowName[r], "iOrD", rowAddr[r], seenAddr);
                if (seenBranch != rowBranch[r]) begin
                    reportMismatch(rowName[r], "branchCond", rowBranch[r], seenBranch);
                end
                if (!decodeLoad) begin
                    $display("%0s did not load A and B in the decode cycle", rowName[r]);
                    otherErrors++;
                end
                if (excJumpSeen != rowEvents[r][4]) begin
                    reportMismatch(rowName[r], "handler jump", rowEvents[r][4], excJumpSeen);
                end
                expMdr = (rowWb[r][3:0] == wbMdr) || rowEvents[r][4];  // lw or handler fetch
                if (mdrLoads != int'(expMdr)) begin
                    reportMismatch(rowName[r], "mdrLoad count", expMdr, mdrLoads);
                end
                if (wbCount > 1) begin
                    $display("%0s wrote the register file more than once", rowName[r]);
                    otherErrors++;
                end
                if (repeats != 0) begin
                    $display("%0s raised a control event more than once", rowName[r]);
                    otherErrors++;
                end
            end
        end
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // longest instruction per row, plus reset
    initial begin : watchdog
        wait (rowsLoaded);
        #((rowCount * (6 + multWaitCycles) + resetCycles + 4) * clkPeriod);
        $display("watchdog expired before the golden rows were done");
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherErrors + 1);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== hw/mipsControlUnit.sv ====
module mipsControlUnit
    import isaPkg::*, ctrlPkg::*;
#(
    parameter int multWaitCycles = 33
) (
    input  logic     clk,
    input  logic     rstN,
    input  opcodeT   opcode,
    input  functT    funct,
    input  logic     overflow,
    output ctrlWordT ctrl
);

    instrClassT instrClass;
    ctrlStateT  state;

    instrDecoder u_decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer #(
        .multWaitCycles (multWaitCycles)
    ) u_sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state)
    );

    // moore outputs, straight from state
    controlWordGen u_wordGen (
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

// ==== hw/controlWordGen.sv ====
module controlWordGen
    import ctrlPkg::*;
(
    input  ctrlStateT state,
    output ctrlWordT  ctrl
);

    // memory samples its address in the issue cycle, so iOrD is only set there
    always_comb begin
        ctrl = ctrlIdle;
        case (state)
            stSpInit: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstSp;
                ctrl.memToReg = wbSpInitConst;
            end

            stFetchPc: begin  // pc <= pc + 4, read at old pc
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcSeq;
                ctrl.iOrD    = addrPc;
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = srcBFour;
                ctrl.aluOp   = aluAdd;
            end

            stFetchIr: begin
                ctrl.irWrite = 1'b1;
            end

            stDecode: begin
                ctrl.regALoad    = 1'b1;
                ctrl.regBLoad    = 1'b1;
                ctrl.aluSrcA     = 1'b0;
                ctrl.aluSrcB     = srcBShiftedImm;  // branch target ahead of time
                ctrl.aluOp       = aluAdd;
                ctrl.aluOutWrite = 1'b1;
            end

            stAluR, stAluSub, stAluAnd, stSltR: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = srcBRegB;
                ctrl.aluOutWrite = 1'b1;
                case (state)
                    stAluSub: ctrl.aluOp = aluSub;
                    stAluAnd: ctrl.aluOp = aluAnd;
                    stSltR:   ctrl.aluOp = aluSlt;
                    default:  ctrl.aluOp = aluAdd;
                endcase
                ctrl.aluOutSrc = (state == stSltR);
            end

            stAluImm, stSltImm, stMemAddr: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = srcBSignImm;
                ctrl.aluOp       = (state == stSltImm) ? aluSlt : aluAdd;
                ctrl.aluOutSrc   = (state == stSltImm);
                ctrl.aluOutWrite = 1'b1;
            end

            stRegWbRd: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRd;
                ctrl.memToReg = wbAluOut;
            end

            stRegWbRt: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRt;
                ctrl.memToReg = wbAluOut;
            end

            stLoadRead: begin
                ctrl.iOrD = addrAluOut;
            end

            stLoadMdr, stExcLoad: begin
                ctrl.mdrLoad = 1'b1;
            end

            stLoadWb: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRt;
                ctrl.memToReg = wbMdr;
            end

            stStore: begin
                ctrl.iOrD     = addrAluOut;
                ctrl.memWrite = 1'b1;
            end

            stBranchEq, stBranchNe: begin  // compare by subtraction
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = srcBRegB;
                ctrl.aluOp       = aluSub;
                ctrl.pcSrc       = pcBranch;
                ctrl.pcWriteCond = 1'b1;
                ctrl.branchCond  = (state == stBranchEq) ? brEq : brNe;
            end

            stJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRa;
                ctrl.memToReg = wbPcLink;
            end

            stJump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcJump;
            end

            stMultStart: ctrl.multStart = 1'b1;
            stMultDone:  ctrl.hiLoWrite = 1'b1;

            stExcOvf, stExcOpcode: begin  // epc <= pc - 4, fetch vector word
                ctrl.epcWrite = 1'b1;
                ctrl.iOrD     = (state == stExcOvf) ? addrOverflowVector : addrOpcodeVector;
                ctrl.aluSrcA  = 1'b0;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluSub;
            end

            stExcJump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcExcVector;
            end

            default: ctrl = ctrlIdle;  // reset and wait states
        endcase
    end

endmodule

// ==== hw/controlSequencer.sv ====
module controlSequencer
    import isaPkg::*, ctrlPkg::*;
#(
    parameter int multWaitCycles = 33
) (
    input  logic       clk,
    input  logic       rstN,
    input  instrClassT instrClass,
    input  logic       overflow,
    output ctrlStateT  state
);

    localparam int cntW = $clog2(multWaitCycles + 1);

    ctrlStateT       nextState;
    logic [cntW-1:0] waitCnt;
    logic            waitDone;
    logic            immTrap;

    assign waitDone = (waitCnt == '0);
    assign immTrap  = (instrClass == clsAddi) && overflow;  // addiu never traps

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stReset;
            waitCnt <= '0;
        end else begin
            state <= nextState;
            // loaded on the way into stMultWait, so it stays there multWaitCycles cycles
            if (state == stMultStart) begin
                waitCnt <= cntW'(multWaitCycles - 1);
            end else if ((state == stMultWait) && !waitDone) begin
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

    always_comb begin
        nextState = stFetchPc;
        case (state)
            stReset:     nextState = stSpInit;
            stSpInit:    nextState = stFetchPc;
            stFetchPc:   nextState = stFetchWait;
            stFetchWait: nextState = stFetchIr;
            stFetchIr:   nextState = stDecode;

            stDecode: begin
                case (instrClass)
                    clsAdd:   nextState = stAluR;
                    clsSub:   nextState = stAluSub;
                    clsAnd:   nextState = stAluAnd;
                    clsSlt:   nextState = stSltR;
                    clsAddi,
                    clsAddiu: nextState = stAluImm;
                    clsSlti:  nextState = stSltImm;
                    clsLw,
                    clsSw:    nextState = stMemAddr;
                    clsBeq:   nextState = stBranchEq;
                    clsBne:   nextState = stBranchNe;
                    clsJ:     nextState = stJump;
                    clsJal:   nextState = stJal;
                    clsMult:  nextState = stMultStart;
                    default:  nextState = stExcOpcode;
                endcase
            end

            stAluR,
            stAluSub:  nextState = overflow ? stExcOvf : stRegWbRd;
            stAluAnd,
            stSltR:    nextState = stRegWbRd;
            stAluImm:  nextState = immTrap ? stExcOvf : stRegWbRt;
            stSltImm:  nextState = stRegWbRt;
            stRegWbRd,
            stRegWbRt: nextState = stFetchPc;

            stMemAddr:  nextState = (instrClass == clsSw) ? stStore : stLoadRead;
            stLoadRead: nextState = stLoadWait;
            stLoadWait: nextState = stLoadMdr;
            stLoadMdr:  nextState = stLoadWb;
            stLoadWb,
            stStore:    nextState = stFetchPc;

            stBranchEq,
            stBranchNe: nextState = stFetchPc;
            stJal:      nextState = stJump;  // link first, then jump
            stJump:     nextState = stFetchPc;

            stMultStart: nextState = stMultWait;
            stMultWait:  nextState = waitDone ? stMultDone : stMultWait;
            stMultDone:  nextState = stFetchPc;

            stExcOvf,
            stExcOpcode: nextState = stExcWait;
            stExcWait:   nextState = stExcLoad;
            stExcLoad:   nextState = stExcJump;
            stExcJump:   nextState = stFetchPc;

            default: nextState = stReset;
        endcase
    end

endmodule

// ==== hw/instrDecoder.sv ====
module instrDecoder
    import isaPkg::*;
(
    input  opcodeT     opcode,
    input  functT      funct,
    output instrClassT instrClass
);

    instrClassT rClass;

    // funct only matters under the r-type opcode
    always_comb begin
        case (funct)
            fnAdd:   rClass = clsAdd;
            fnSub:   rClass = clsSub;
            fnAnd:   rClass = clsAnd;
            fnSlt:   rClass = clsSlt;
            fnMult:  rClass = clsMult;
            default: rClass = clsInvalid;
        endcase
    end

    always_comb begin
        case (opcode)
            opRType: begin
                instrClass = rClass;
            end
            opAddi: begin
                instrClass = clsAddi;
            end
            opAddiu: begin
                instrClass = clsAddiu;  // no overflow trap
            end
            opSlti: begin
                instrClass = clsSlti;
            end
            opLw: begin
                instrClass = clsLw;
            end
            opSw: begin
                instrClass = clsSw;
            end
            opBeq: begin
                instrClass = clsBeq;
            end
            opBne: begin
                instrClass = clsBne;
            end
            opJ: begin
                instrClass = clsJ;
            end
            opJal: begin
                instrClass = clsJal;
            end
            default: begin
                instrClass = clsInvalid;
            end
        endcase
    end

endmodule

// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

    typedef enum logic [4:0] {
        stReset,      // held while rstN is low
        stSpInit,
        stFetchPc,
        stFetchWait,
        stFetchIr,
        stDecode,
        stAluR,       // add
        stAluSub,
        stAluAnd,
        stAluImm,     // addi and addiu
        stSltR,
        stSltImm,
        stRegWbRd,
        stRegWbRt,
        stMemAddr,
        stLoadRead,
        stLoadWait,
        stLoadMdr,
        stLoadWb,
        stStore,
        stBranchEq,
        stBranchNe,
        stJal,
        stJump,
        stMultStart,
        stMultWait,
        stMultDone,
        stExcOvf,
        stExcOpcode,
        stExcWait,
        stExcLoad,
        stExcJump
    } ctrlStateT;

    typedef enum logic [2:0] {
        pcSeq       = 3'd0,
        pcBranch    = 3'd1,  // target held in aluOut
        pcJump      = 3'd2,
        pcExcVector = 3'd3   // handler address from mdr
    } pcSrcT;

    typedef enum logic [2:0] {
        addrPc             = 3'd0,
        addrAluOut         = 3'd1,
        addrOpcodeVector   = 3'd2,
        addrOverflowVector = 3'd3
    } addrSelT;

    typedef enum logic [1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2,
        dstSp = 2'd3
    } regDstT;

    typedef enum logic [3:0] {
        wbAluOut      = 4'd0,
        wbMdr         = 4'd1,
        wbPcLink      = 4'd6,
        wbSpInitConst = 4'd7
    } wbSrcT;

    typedef enum logic [1:0] {
        srcBRegB       = 2'd0,
        srcBFour       = 2'd1,
        srcBSignImm    = 2'd2,
        srcBShiftedImm = 2'd3
    } aluSrcBT;

    typedef enum logic [2:0] {
        aluPass = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3,
        aluSlt  = 3'd7
    } aluOpT;

    typedef enum logic [1:0] {
        brNone = 2'd0,
        brNe   = 2'd1,
        brEq   = 2'd2
    } branchCondT;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        branchCondT branchCond;
        pcSrcT      pcSrc;
        addrSelT    iOrD;
        logic       memWrite;
        logic       irWrite;
        logic       mdrLoad;
        logic       regWrite;
        regDstT     regDst;
        wbSrcT      memToReg;
        logic       regALoad;
        logic       regBLoad;
        logic       aluSrcA;      // 0 pc, 1 reg A
        aluSrcBT    aluSrcB;
        aluOpT      aluOp;
        logic       aluOutSrc;    // 1 selects the less-than flag
        logic       aluOutWrite;
        logic       epcWrite;
        logic       hiLoWrite;
        logic       multStart;
    } ctrlWordT;

    // every enum above encodes its inactive choice as zero
    localparam ctrlWordT ctrlIdle = '0;

endpackage

// ==== hw/isaPkg.sv ====
package isaPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // primary opcodes
    localparam opcodeT opRType = 6'h00;  // funct selects the op
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    // r-type funct codes
    localparam functT fnMult = 6'h18;
    localparam functT fnAdd  = 6'h20;
    localparam functT fnSub  = 6'h22;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnSlt  = 6'h2a;

    // one class per supported instruction
    typedef enum logic [3:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSlt,
        clsMult,
        clsAddi,
        clsAddiu,
        clsSlti,
        clsLw,
        clsSw,
        clsBeq,
        clsBne,
        clsJ,
        clsJal,
        clsInvalid  // takes the opcode exception
    } instrClassT;

endpackage
